//--- pit_config.svh
`ifndef PIT_CONFIG_SVH
`define PIT_CONFIG_SVH

// --------------------
// Datapath widths
// --------------------

// Host data bus, one byte per access
`define PIT_DATA_W 8

// Counting element, four BCD decades or 16 binary bits
`define PIT_COUNT_W 16

// --------------------
// Control word after reset
// --------------------

// Rate generator
`define PIT_RST_MODE 3'd2

// LSB only
`define PIT_RST_RW 2'd1

`endif

//--- pit_pkg.sv
`default_nettype none

package pit_pkg;

    // Counting modes, 6 and 7 decode as 2 and 3
    typedef enum logic [2:0] {
        MODE_INT_TC     = 3'd0,
        MODE_ONE_SHOT   = 3'd1,
        MODE_RATE_GEN   = 3'd2,
        MODE_SQUARE     = 3'd3,
        MODE_SW_STROBE  = 3'd4,
        MODE_HW_STROBE  = 3'd5,
        MODE_RATE_GEN_X = 3'd6,
        MODE_SQUARE_X   = 3'd7
    } pit_mode_e;

    // Read/write byte modes
    typedef enum logic [1:0] {
        RW_LATCH   = 2'd0,
        RW_LSB     = 2'd1,
        RW_MSB     = 2'd2,
        RW_LSB_MSB = 2'd3
    } pit_rw_e;

    // Control word bits 5 to 0
    typedef struct packed {
        pit_rw_e   rw_mode;
        pit_mode_e mode;
        logic      bcd;
    } pit_ctrl_t;

    // Host strobes, at most one active at a time
    typedef struct packed {
        logic set_control_mode;
        logic latch_count;
        logic latch_status;
        logic write;
        logic read;
    } pit_host_t;

    // Sampled events from the input stage
    typedef struct packed {
        logic clock_rise;
        logic clock_fall;
        logic gate_fall;
        logic gate_level;
        logic write_done;
    } pit_edges_t;

endpackage

`default_nettype wire

//--- pit_input_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module pit_input_sampler
    import pit_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clock,
    input  logic       gate,
    input  logic       write,
    input  logic       read,
    output pit_edges_t edges,
    output logic       read_done
);

    // One cycle of history per input
    logic clock_q;
    logic gate_q;
    logic write_q;
    logic read_q;
    // Gate level as seen at the last counter clock rise
    logic gate_level;
    logic clock_rise;

    assign clock_rise = clock && !clock_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clock_q <= 1'b0;
            gate_q  <= 1'b0;
            write_q <= 1'b0;
            read_q  <= 1'b0;
        end else begin
            clock_q <= clock;
            gate_q  <= gate;
            write_q <= write;
            read_q  <= read;
        end
    end

    // Gate only matters at the rising edge of the counter clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gate_level <= 1'b0;
        end else if (clock_rise) begin
            gate_level <= gate;
        end
    end

    // Strobe falls mark completed accesses
    assign edges = '{
        clock_rise: clock_rise,
        clock_fall: clock_q && !clock,
        gate_fall:  gate_q && !gate,
        gate_level: gate_level,
        write_done: write_q && !write
    };
    assign read_done = read_q && !read;

endmodule

`default_nettype wire

//--- pit_host_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "pit_config.svh"

module pit_host_port
    import pit_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  pit_host_t               host,
    input  logic [`PIT_DATA_W-1:0]  data_in,
    input  logic                    read_done,
    input  logic                    write_done,
    input  logic                    load,
    input  logic [`PIT_COUNT_W-1:0] count,
    input  logic                    out,
    output pit_ctrl_t               ctrl,
    output logic [`PIT_COUNT_W-1:0] reload,
    output logic                    write_seq_done,
    output logic                    write_seq_msb,
    output logic [`PIT_DATA_W-1:0]  data_out
);

    logic                   read_seq_msb;
    logic                   read_seq_done;
    logic                   write_lsb;
    logic                   write_msb;
    logic                   two_byte;
    // Count register halves
    logic [`PIT_DATA_W-1:0] cr_l;
    logic [`PIT_DATA_W-1:0] cr_m;
    // Output latch halves
    logic [`PIT_DATA_W-1:0] ol_l;
    logic [`PIT_DATA_W-1:0] ol_m;
    logic                   output_latched;
    logic [`PIT_DATA_W-1:0] status;
    logic                   status_latched;
    logic                   null_count;

    // --------------------
    // Control word
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl <= '{rw_mode: pit_rw_e'(`PIT_RST_RW),
                      mode:    pit_mode_e'(`PIT_RST_MODE),
                      bcd:     1'b0};
        end else if (host.set_control_mode) begin
            ctrl <= pit_ctrl_t'(data_in[5:0]);
        end
    end

    assign two_byte = (ctrl.rw_mode == RW_LSB_MSB);

    // --------------------
    // Byte sequencing
    // --------------------

    // High means the MSB comes next in LSB/MSB mode
    always_ff @(posedge clk) begin
        if (!rst_n || host.set_control_mode) begin
            write_seq_msb <= 1'b0;
            read_seq_msb  <= 1'b0;
        end else begin
            if (write_done && two_byte) begin
                write_seq_msb <= !write_seq_msb;
            end
            // Status reads do not advance the count sequence
            if (read_done && two_byte && !status_latched) begin
                read_seq_msb <= !read_seq_msb;
            end
        end
    end

    assign write_seq_done = write_done && (!two_byte || write_seq_msb);
    assign read_seq_done  = read_done && !status_latched && (!two_byte || read_seq_msb);

    assign write_lsb = host.write && (ctrl.rw_mode != RW_MSB) && !write_seq_msb;
    assign write_msb = host.write && ((ctrl.rw_mode == RW_MSB) || write_seq_msb);

    // Single byte modes clear the byte that is not written
    always_ff @(posedge clk) begin
        if (host.write && ctrl.rw_mode == RW_MSB) begin
            cr_l <= '0;
        end else if (write_lsb) begin
            cr_l <= data_in;
        end
        if (host.write && ctrl.rw_mode == RW_LSB) begin
            cr_m <= '0;
        end else if (write_msb) begin
            cr_m <= data_in;
        end
    end

    assign reload = {cr_m, cr_l};

    // --------------------
    // Latches and readback
    // --------------------

    // Follows the counting element until frozen by a latch command
    always_ff @(posedge clk) begin
        if (!output_latched) begin
            ol_l <= count[7:0];
            ol_m <= count[15:8];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || host.set_control_mode) begin
            output_latched <= 1'b0;
        end else if (host.latch_count) begin
            output_latched <= 1'b1;
        end else if (read_seq_done) begin
            output_latched <= 1'b0;
        end
    end

    // A second status latch before readback keeps the first snapshot
    always_ff @(posedge clk) begin
        if (host.latch_status && !status_latched) begin
            status <= {out, null_count, ctrl};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || host.set_control_mode) begin
            status_latched <= 1'b0;
        end else if (host.latch_status) begin
            status_latched <= 1'b1;
        end else if (read_done) begin
            status_latched <= 1'b0;
        end
    end

    // Set by new programming, cleared once the count reaches the counting element
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            null_count <= 1'b0;
        end else if (host.set_control_mode || write_seq_done) begin
            null_count <= 1'b1;
        end else if (load) begin
            null_count <= 1'b0;
        end
    end

    // Status has priority over the count
    assign data_out = status_latched                                  ? status :
                      (ctrl.rw_mode == RW_MSB || read_seq_msb)        ? ol_m   : ol_l;

    // Programming and data writes share the data bus
    a_ctrl_not_with_write: assert property (
        @(posedge clk) disable iff (!rst_n) !(host.set_control_mode && host.write));

endmodule

`default_nettype wire

//--- pit_load_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "pit_config.svh"

module pit_load_ctrl
    import pit_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  pit_edges_t              edges,
    input  pit_ctrl_t               ctrl,
    input  logic                    set_control_mode,
    input  logic                    write_seq_done,
    input  logic                    write_seq_msb,
    input  logic [`PIT_COUNT_W-1:0] count,
    input  logic                    reload_lsb0,
    input  logic                    out,
    output logic                    load,
    output logic                    enable,
    output logic                    loaded
);

    logic written;
    logic written_sampled;
    logic terminal_count;
    // Modes 2 and 3 and their aliases
    logic periodic;
    // Modes 1 and 5 have no load event here
    logic triggered_mode;
    logic load_written;
    logic load_terminal;

    assign periodic       = ctrl.mode[1];
    assign triggered_mode = (ctrl.mode[1:0] == 2'b01);

    // Pending load after a full write sequence
    // Periodic modes pick up a rewritten count at terminal count instead
    always_ff @(posedge clk) begin
        if (!rst_n || set_control_mode) begin
            written <= 1'b0;
        end else if (write_seq_done && !triggered_mode && !(periodic && loaded)) begin
            written <= 1'b1;
        end else if (load) begin
            written <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || set_control_mode) begin
            written_sampled <= 1'b0;
        end else if (edges.clock_rise) begin
            written_sampled <= written;
        end
    end

    // Terminal count is 1 in mode 2
    // Mode 3 stops at 0 for the odd high half, else at 2
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            terminal_count <= 1'b0;
        end else begin
            terminal_count <= count == {14'd0, ctrl.mode[0] && !(reload_lsb0 && out),
                                        !ctrl.mode[0]};
        end
    end

    // --------------------
    // Step events on counter clock fall
    // --------------------

    assign load_written  = edges.clock_fall && written_sampled;
    assign load_terminal = edges.clock_fall && periodic && terminal_count && loaded &&
                           edges.gate_level;
    assign load          = load_written || load_terminal;

    always_ff @(posedge clk) begin
        if (!rst_n || set_control_mode) begin
            loaded <= 1'b0;
        end else if (load) begin
            loaded <= 1'b1;
        end
    end

    // Mode 0 pauses while only the LSB of a new count is in
    assign enable = edges.clock_fall && !load && loaded && edges.gate_level &&
                    !(ctrl.mode == MODE_INT_TC && write_seq_msb);

    // Step events are one clk wide
    a_step_one_clk: assert property (
        @(posedge clk) disable iff (!rst_n)
        (load || enable) |=> !(load || enable));

endmodule

`default_nettype wire

//--- pit_counting_element.sv
`timescale 1ns/1ps
`default_nettype none
`include "pit_config.svh"

module pit_counting_element
    import pit_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  pit_ctrl_t               ctrl,
    input  logic [`PIT_COUNT_W-1:0] reload,
    input  logic                    load,
    input  logic                    enable,
    output logic [`PIT_COUNT_W-1:0] count
);

    logic                    square;
    logic [`PIT_COUNT_W-1:0] bcd_dec;
    logic [`PIT_COUNT_W-1:0] one_step;
    logic                    borrow;

    function automatic logic bcd_valid(input logic [`PIT_COUNT_W-1:0] value);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < 4; i++) begin
            ok = ok && (value[4*i +: 4] <= 4'd9);
        end
        return ok;
    endfunction

    assign square = (ctrl.mode[1:0] == 2'b11);

    // Four decade decrement, 0000 wraps to 9999
    always_comb begin
        bcd_dec = count;
        borrow  = 1'b1;
        for (int i = 0; i < 4; i++) begin
            if (borrow) begin
                if (count[4*i +: 4] == 4'd0) begin
                    bcd_dec[4*i +: 4] = 4'd9;
                end else begin
                    bcd_dec[4*i +: 4] = count[4*i +: 4] - 4'd1;
                    borrow            = 1'b0;
                end
            end
        end
    end

    assign one_step = ctrl.bcd ? bcd_dec : count - `PIT_COUNT_W'(1);

    // Mode 3 loads an even value and steps by two
    // The second step never borrows since the first leaves an odd digit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= {reload[`PIT_COUNT_W-1:1], reload[0] && !square};
        end else if (enable) begin
            count <= one_step - {{(`PIT_COUNT_W-1){1'b0}}, square};
        end
    end

    a_bcd_digits: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ctrl.bcd && enable && bcd_valid(count)) |=> bcd_valid(count));

endmodule

`default_nettype wire

//--- pit_output_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "pit_config.svh"

module pit_output_gen
    import pit_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  pit_ctrl_t               ctrl,
    input  logic                    set_control_mode,
    input  logic [`PIT_DATA_W-1:0]  data_in,
    input  logic                    write_done,
    input  logic                    write_seq_msb,
    input  pit_edges_t              edges,
    input  logic                    load,
    input  logic                    enable,
    input  logic                    loaded,
    input  logic [`PIT_COUNT_W-1:0] count,
    output logic                    out
);

    logic at_one;
    logic at_two;
    logic at_zero;

    // Compares against the count before this step
    assign at_zero = enable && (count == `PIT_COUNT_W'(0));
    assign at_one  = enable && (count == `PIT_COUNT_W'(1));
    assign at_two  = enable && (count == `PIT_COUNT_W'(2));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out <= 1'b1;
        end else if (set_control_mode) begin
            // Only mode 0 starts low
            out <= (data_in[3:1] != 3'd0);
        end else begin
            case (ctrl.mode)
                // Interrupt on terminal count, gate has no effect on out
                MODE_INT_TC: begin
                    if (write_done && !write_seq_msb) begin
                        out <= 1'b0;
                    end else if (at_one) begin
                        out <= 1'b1;
                    end
                end
                // One clock wide low pulse before each reload
                MODE_RATE_GEN, MODE_RATE_GEN_X: begin
                    if (load || edges.gate_fall) begin
                        out <= 1'b1;
                    end else if (at_two) begin
                        out <= 1'b0;
                    end
                end
                // Half period per reload, the first load keeps out high
                MODE_SQUARE, MODE_SQUARE_X: begin
                    if (edges.gate_fall) begin
                        out <= 1'b1;
                    end else if (load && loaded) begin
                        out <= !out;
                    end
                end
                // Strobe low for the step from 1 to 0
                MODE_SW_STROBE: begin
                    if (at_one) begin
                        out <= 1'b0;
                    end else if (at_zero) begin
                        out <= 1'b1;
                    end
                end
                // Modes 1 and 5 keep the control write level
                default: begin
                    out <= out;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pit_counter.sv
`timescale 1ns/1ps
`default_nettype none
`include "pit_config.svh"

module pit_counter
    import pit_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clock,
    input  logic                   gate,
    input  pit_host_t              host,
    input  logic [`PIT_DATA_W-1:0] data_in,
    output logic                   out,
    output logic [`PIT_DATA_W-1:0] data_out
);

    pit_edges_t              edges;
    logic                    read_done;
    pit_ctrl_t               ctrl;
    logic [`PIT_COUNT_W-1:0] reload;
    logic                    write_seq_done;
    logic                    write_seq_msb;
    logic                    load;
    logic                    enable;
    logic                    loaded;
    logic [`PIT_COUNT_W-1:0] count;

    // --------------------
    // Input stage and host side
    // --------------------

    pit_input_sampler u_sampler (
        .clk       (clk),
        .rst_n     (rst_n),
        .clock     (clock),
        .gate      (gate),
        .write     (host.write),
        .read      (host.read),
        .edges     (edges),
        .read_done (read_done)
    );

    pit_host_port u_host_port (
        .clk            (clk),
        .rst_n          (rst_n),
        .host           (host),
        .data_in        (data_in),
        .read_done      (read_done),
        .write_done     (edges.write_done),
        .load           (load),
        .count          (count),
        .out            (out),
        .ctrl           (ctrl),
        .reload         (reload),
        .write_seq_done (write_seq_done),
        .write_seq_msb  (write_seq_msb),
        .data_out       (data_out)
    );

    // --------------------
    // Counting path
    // --------------------

    pit_load_ctrl u_load_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .edges            (edges),
        .ctrl             (ctrl),
        .set_control_mode (host.set_control_mode),
        .write_seq_done   (write_seq_done),
        .write_seq_msb    (write_seq_msb),
        .count            (count),
        .reload_lsb0      (reload[0]),
        .out              (out),
        .load             (load),
        .enable           (enable),
        .loaded           (loaded)
    );

    pit_counting_element u_counting_element (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (ctrl),
        .reload (reload),
        .load   (load),
        .enable (enable),
        .count  (count)
    );

    pit_output_gen u_output_gen (
        .clk              (clk),
        .rst_n            (rst_n),
        .ctrl             (ctrl),
        .set_control_mode (host.set_control_mode),
        .data_in          (data_in),
        .write_done       (edges.write_done),
        .write_seq_msb    (write_seq_msb),
        .edges            (edges),
        .load             (load),
        .enable           (enable),
        .loaded           (loaded),
        .count            (count),
        .out              (out)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset low for 8 cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_pit_model.svh
`ifndef TB_PIT_MODEL_SVH
`define TB_PIT_MODEL_SVH

// Control word byte, counter select bits left at 0
function automatic logic [7:0] control_word(input logic [1:0] rw, input logic [2:0] mode,
                                            input logic bcd);
    return {2'b00, rw, mode, bcd};
endfunction

// Status byte as returned after a status latch
function automatic logic [7:0] status_byte(input logic out_level, input logic null_count,
                                           input logic [1:0] rw, input logic [2:0] mode,
                                           input logic bcd);
    return {out_level, null_count, rw, mode, bcd};
endfunction

// Mode 0 count after k pulses
// First pulse only loads the count register
function automatic logic [15:0] mode0_count(input logic [15:0] n, input int k);
    return n - 16'(k - 1);
endfunction

// Four decades through a decimal integer, 0000 wraps to 9999
function automatic logic [15:0] bcd_decrement(input logic [15:0] value);
    int          dec;
    logic [15:0] result;
    dec = 1000 * int'(value[15:12]) + 100 * int'(value[11:8]) +
          10 * int'(value[7:4]) + int'(value[3:0]);
    dec = (dec + 9999) % 10000;
    result[15:12] = 4'(dec / 1000);
    result[11:8]  = 4'((dec / 100) % 10);
    result[7:4]   = 4'((dec / 10) % 10);
    result[3:0]   = 4'(dec % 10);
    return result;
endfunction

function automatic logic bcd_byte_valid(input logic [7:0] value);
    return (value[7:4] <= 4'd9) && (value[3:0] <= 4'd9);
endfunction

// Mode 2 out after pulse j, low for the pulse that brings the count to 1
function automatic logic mode2_out_level(input int n, input int j);
    return (j >= n && j % n == 0) ? 1'b0 : 1'b1;
endfunction

// Mode 3 out after pulse j, even n, starts high and flips every n/2 pulses
function automatic logic mode3_out_level(input int n, input int j);
    return ((j - 1) / (n / 2)) % 2 == 0;
endfunction

`endif

//--- tb_pit_counter.sv
`timescale 1ns/1ps
`default_nettype none
`include "pit_config.svh"

module tb_pit_counter
    import pit_pkg::*;
();

    `include "tb_pit_model.svh"

    // Pulses allowed for out to change level
    localparam int PULSE_LIMIT = 8;

    logic                   clk;
    logic                   rst_n;
    logic                   clock;
    logic                   gate;
    pit_host_t              host;
    logic [`PIT_DATA_W-1:0] data_in;
    logic                   out;
    logic [`PIT_DATA_W-1:0] data_out;

    // Pending checks, drained on each rising edge
    string       chk_name_q[$];
    logic [31:0] chk_got_q[$];
    logic [31:0] chk_exp_q[$];

    int test_errors;
    int total_errors;
    int tests_run;
    int tests_failed;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pit_counter dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .clock    (clock),
        .gate     (gate),
        .host     (host),
        .data_in  (data_in),
        .out      (out),
        .data_out (data_out)
    );

    // --------------------
    // Compare process
    // --------------------

    always @(posedge clk) begin : compare
        string       name;
        logic [31:0] got;
        logic [31:0] exp_val;
        while (chk_got_q.size() > 0) begin
            name    = chk_name_q.pop_front();
            got     = chk_got_q.pop_front();
            exp_val = chk_exp_q.pop_front();
            if (got !== exp_val) begin
                $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp_val);
                test_errors = test_errors + 1;
            end
        end
    end

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp_val);
        chk_name_q.push_back(name);
        chk_got_q.push_back(got);
        chk_exp_q.push_back(exp_val);
    endtask

    task automatic finish_test(input string name);
        // The compare process runs on the rising edge in between
        @(negedge clk);
        tests_run = tests_run + 1;
        if (test_errors == 0) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("Test %0d %s: failed with %0d errors", tests_run, name, test_errors);
        end
        total_errors = total_errors + test_errors;
        test_errors  = 0;
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout, %s", what);
        $display("Simulation failed");
        $finish;
    endtask

    // --------------------
    // Host and counter clock drivers
    // --------------------

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 100) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (rst_n !== 1'b1) begin
            fail_timeout("reset was not released within 100 clk cycles");
        end
    endtask

    // 3 clk high, 3 clk low
    task automatic counter_pulse();
        @(negedge clk);
        clock = 1'b1;
        repeat (3) @(negedge clk);
        clock = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic wait_out(input logic level, input int limit, output int pulses);
        pulses = 0;
        while (out !== level && pulses < limit) begin
            counter_pulse();
            pulses = pulses + 1;
        end
        if (out !== level) begin
            fail_timeout($sformatf("out did not reach %0b within %0d counter clock pulses",
                                   level, limit));
        end
    endtask

    task automatic program_control(input logic [7:0] cw);
        @(negedge clk);
        data_in               = cw;
        host.set_control_mode = 1'b1;
        @(negedge clk);
        host.set_control_mode = 1'b0;
    endtask

    // Data stays on the bus until the next access
    task automatic write_byte(input logic [7:0] value);
        @(negedge clk);
        data_in    = value;
        host.write = 1'b1;
        @(negedge clk);
        host.write = 1'b0;
        @(negedge clk);
    endtask

    task automatic latch_counter();
        @(negedge clk);
        host.latch_count = 1'b1;
        @(negedge clk);
        host.latch_count = 1'b0;
    endtask

    // data_out sampled while read is high
    task automatic read_byte(output logic [7:0] value);
        @(negedge clk);
        host.read = 1'b1;
        @(negedge clk);
        value     = data_out;
        host.read = 1'b0;
        @(negedge clk);
    endtask

    task automatic read_count_bytes(input logic two_bytes, output logic [15:0] value);
        logic [7:0] lo;
        logic [7:0] hi;
        hi = 8'h00;
        read_byte(lo);
        if (two_bytes) begin
            read_byte(hi);
        end
        value = {hi, lo};
    endtask

    task automatic read_latched_count(input logic two_bytes, output logic [15:0] value);
        latch_counter();
        read_count_bytes(two_bytes, value);
    endtask

    task automatic read_status(output logic [7:0] value);
        @(negedge clk);
        host.latch_status = 1'b1;
        @(negedge clk);
        host.latch_status = 1'b0;
        read_byte(value);
    endtask

    // --------------------
    // Tests
    // --------------------

    initial begin : stimulus
        logic [15:0] n;
        logic [15:0] v;
        logic [15:0] held;
        logic [15:0] bcd_exp;
        logic [7:0]  b;
        logic [7:0]  st;
        int          taken;
        int          k;
        int          j;

        void'($urandom(32'h99));
        clock        = 1'b0;
        gate         = 1'b1;
        host         = '0;
        data_in      = '0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        wait_reset();

        // Reset state seen through the status byte
        read_status(st);
        expect_value("data_out", 32'(st),
                     32'(status_byte(1'b1, 1'b0, RW_LSB, MODE_RATE_GEN, 1'b0)));
        expect_value("out", 32'(out), 32'h1);
        finish_test("reset status");

        // Mode 0 with an MSB that is never zero
        n = 16'($urandom_range(459, 260));
        program_control(control_word(RW_LSB_MSB, MODE_INT_TC, 1'b0));
        write_byte(n[7:0]);
        write_byte(n[15:8]);
        expect_value("out", 32'(out), 32'h0);
        for (k = 1; k <= int'(n); k++) begin
            counter_pulse();
            expect_value("out", 32'(out), 32'h0);
            if (k <= 3 || k == int'(n) / 2 || k == int'(n)) begin
                read_latched_count(1'b1, v);
                expect_value("data_out", 32'(v), 32'(mode0_count(n, k)));
            end
        end
        wait_out(1'b1, PULSE_LIMIT, taken);
        expect_value("out high pulse count", 32'(taken), 32'h1);
        finish_test("mode 0 binary");

        // Mode 2, two full periods then a gate stop
        n = 16'($urandom_range(20, 3));
        program_control(control_word(RW_LSB, MODE_RATE_GEN, 1'b0));
        write_byte(n[7:0]);
        for (j = 1; j <= 2 * int'(n); j++) begin
            counter_pulse();
            expect_value("out", 32'(out), 32'(mode2_out_level(int'(n), j)));
        end
        // Gate falls during the low pulse while the count sits at 1
        gate = 1'b0;
        read_latched_count(1'b0, held);
        expect_value("data_out", 32'(held), 32'h1);
        expect_value("out", 32'(out), 32'h1);
        repeat (3) begin
            counter_pulse();
            expect_value("out", 32'(out), 32'h1);
        end
        read_latched_count(1'b0, v);
        expect_value("data_out", 32'(v), 32'(held));
        // Held count is the terminal count, so the first pulse reloads
        gate = 1'b1;
        counter_pulse();
        read_latched_count(1'b0, v);
        expect_value("data_out", 32'(v), 32'(n));
        counter_pulse();
        read_latched_count(1'b0, v);
        expect_value("data_out", 32'(v), 32'(n - 16'd1));
        finish_test("mode 2 rate and gate");

        // Mode 3 with an even count
        n = 16'(2 * $urandom_range(10, 2));
        program_control(control_word(RW_LSB, MODE_SQUARE, 1'b0));
        write_byte(n[7:0]);
        for (j = 1; j <= 2 * int'(n) + 1; j++) begin
            counter_pulse();
            expect_value("out", 32'(out), 32'(mode3_out_level(int'(n), j)));
        end
        finish_test("mode 3 square wave");

        // BCD mode 0 across the first decade borrow
        program_control(control_word(RW_LSB_MSB, MODE_INT_TC, 1'b1));
        write_byte(8'h00);
        write_byte(8'h01);
        bcd_exp = 16'h0100;
        for (k = 1; k <= 12; k++) begin
            counter_pulse();
            if (k > 1) begin
                bcd_exp = bcd_decrement(bcd_exp);
            end
            read_latched_count(1'b1, v);
            expect_value("data_out", 32'(v), 32'(bcd_exp));
            expect_value("data_out msb bcd digits", 32'(bcd_byte_valid(v[15:8])), 32'h1);
        end
        finish_test("mode 0 bcd");

        // Single byte write leaves the count MSB at 0
        b = 8'($urandom_range(255, 2));
        program_control(control_word(RW_LSB, MODE_INT_TC, 1'b0));
        write_byte(b);
        counter_pulse();
        read_latched_count(1'b0, v);
        expect_value("data_out", 32'(v), 32'({8'h00, b}));
        program_control(control_word(RW_LSB_MSB, MODE_INT_TC, 1'b0));
        read_latched_count(1'b1, v);
        expect_value("data_out", 32'(v), 32'({8'h00, b}));

        // Latched value survives further pulses until read
        n = 16'($urandom_range(16'hf000, 16'h1000));
        write_byte(n[7:0]);
        write_byte(n[15:8]);
        counter_pulse();
        counter_pulse();
        latch_counter();
        repeat (3) counter_pulse();
        read_count_bytes(1'b1, v);
        expect_value("data_out", 32'(v), 32'(mode0_count(n, 2)));
        read_latched_count(1'b1, v);
        expect_value("data_out", 32'(v), 32'(mode0_count(n, 5)));

        // Null count set by the control word, cleared by the load
        program_control(control_word(RW_LSB_MSB, MODE_RATE_GEN, 1'b0));
        read_status(st);
        expect_value("data_out", 32'(st),
                     32'(status_byte(1'b1, 1'b1, RW_LSB_MSB, MODE_RATE_GEN, 1'b0)));
        write_byte(8'h10);
        write_byte(8'h00);
        counter_pulse();
        read_status(st);
        expect_value("data_out", 32'(st),
                     32'(status_byte(1'b1, 1'b0, RW_LSB_MSB, MODE_RATE_GEN, 1'b0)));
        finish_test("rw modes and latches");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
pit_pkg.sv
pit_input_sampler.sv
pit_host_port.sv
pit_load_ctrl.sv
pit_counting_element.sv
pit_output_gen.sv
pit_counter.sv
tb_clock_gen.sv
tb_pit_counter.sv

//--- Makefile
# Verilator build and run for the PIT counter channel
# Any variable below can be set on the command line, e.g. make LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_pit_counter
RTL_TOP    ?= pit_counter
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The log decides the result, the simulator exit code alone is not enough
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
